/* bus_cpu.f */
+incdir+rtl
rtl/bus_cpu_pkg.sv
rtl/datapath_ctrl_if.sv
rtl/alu_unit.sv
rtl/datapath.sv
rtl/control_sequencer.sv
rtl/bus_cpu.sv
testbench/bus_cpu_tb.sv

/* testbench/bus_cpu_tests.txt */
// records, all hex: 1 = image (address, word count, words), 2 = expected write (address, word)
// 3 = end of group, 0 = end of file
// loada then store
1 00 5 0003 0040 0007 0041 0030
1 40 1 1234
2 41 1234
3
// loadb through the accumulator
1 00 6 0003 0050 0005 0007 0051 0030
1 50 2 0060 0000
1 60 1 beef
2 51 beef
3
// r2 = 7e51, r1 = 9a3c, then add, sub, mul
1 00 8 0003 0080 0027 0003 0081 0026 002a 0007
1 08 8 0090 002b 0007 0091 0029 0007 0092 0030
1 80 2 7e51 9a3c
2 90 188d
2 91 1beb
2 92 54fc
3
// jumpz taken, jumpn skipped, jumpz skipped, jumpn taken
1 00 7 0003 00a0 0009 0010 0007 00b0 0030
1 10 7 000d 0020 0003 00a1 0007 00b1 0009
1 17 6 0030 000d 0028 0007 00b2 0030
1 20 3 0007 00b5 0030
1 28 3 0007 00b3 0030
1 30 3 0007 00b4 0030
1 a0 2 0000 5a5a
2 b1 5a5a
2 b3 5a5a
3
// r2 to r1, clear r2, unknown opcodes 3f and 00
1 00 8 0003 00c0 0027 0014 0003 00c1 0027 002a
1 08 8 0007 00d0 002e 003f 002a 0007 00d1 002f
1 10 2 ab00 0030
1 c0 2 0321 1000
2 d0 1321
2 d1 0321
3
0

/* testbench/bus_cpu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_cpu_tb;

	localparam int max_cycles = 2000;
	localparam int max_writes = 32;
	localparam int data_size = 512;
	localparam int group_total = 5;

	logic clock;
	logic reset;
	logic start;
	bus_cpu_pkg::word_t mem_rdata;
	bus_cpu_pkg::addr_t mem_addr;
	bus_cpu_pkg::word_t mem_wdata;
	logic mem_wr;
	logic end_process;

	// memory model of 256 words
	bus_cpu_pkg::word_t mem [0:255];
	// raw fields of the data file
	logic [15:0] test_data [0:data_size-1];
	int data_pos;

	// memory port as seen mid-cycle
	bus_cpu_pkg::addr_t seen_addr;
	bus_cpu_pkg::word_t seen_wdata;
	logic seen_wr;

	// expected writes of the running group in order
	bus_cpu_pkg::addr_t exp_addr [0:max_writes-1];
	bus_cpu_pkg::word_t exp_word [0:max_writes-1];
	int exp_count;
	int write_count;
	int group;

	bus_cpu bus_cpu_i (
		.clock(clock),
		.reset(reset),
		.start(start),
		.mem_rdata(mem_rdata),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_wr(mem_wr),
		.end_process(end_process)
	);

	// 100 ns period
	always #50 clock = ~clock;

	task automatic stop_run();
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_addr(input bus_cpu_pkg::addr_t got, input bus_cpu_pkg::addr_t expected,
			input string what);
		if (got !== expected) begin
			$display("Mismatch at time %0t: %s: got %h, expected %h", $time, what, got, expected);
			stop_run();
		end
	endtask

	task automatic check_word(input bus_cpu_pkg::word_t got, input bus_cpu_pkg::word_t expected,
			input string what);
		if (got !== expected) begin
			$display("Mismatch at time %0t: %s: got %h, expected %h", $time, what, got, expected);
			stop_run();
		end
	endtask

	task automatic check_count(input int got, input int expected, input string what);
		if (got != expected) begin
			$display("Mismatch at time %0t: %s: got %0d, expected %0d", $time, what, got, expected);
			stop_run();
		end
	endtask

	// fill pattern unique to each address
	task automatic fill_memory();
		int i;
		for (i = 0; i < 256; i++) begin
			mem[i] = {~i[7:0], i[7:0]};
		end
	endtask

	task automatic read_field(output logic [15:0] value);
		if (data_pos >= data_size || $isunknown(test_data[data_pos])) begin
			$display("Test data ends without an end-of-file record, field %0d", data_pos);
			stop_run();
		end
		value = test_data[data_pos];
		data_pos++;
	endtask

	task automatic wait_for_end();
		int cycles;
		cycles = 0;
		while (end_process !== 1'b1 && cycles < max_cycles) begin
			@(negedge clock);
			cycles++;
		end
		if (end_process !== 1'b1) begin
			$display("Timeout: program of group %0d did not halt in %0d cycles", group, max_cycles);
			stop_run();
		end
	endtask

	// port sampled mid-cycle
	// each write goes against the next expected one
	always @(negedge clock) begin
		seen_addr = mem_addr;
		seen_wdata = mem_wdata;
		seen_wr = mem_wr;
		if (mem_wr) begin
			if (write_count >= exp_count) begin
				check_count(write_count + 1, exp_count, $sformatf("writes in group %0d", group));
			end
			check_addr(mem_addr, exp_addr[write_count],
				$sformatf("address of write %0d in group %0d", write_count, group));
			check_word(mem_wdata, exp_word[write_count],
				$sformatf("data of write %0d in group %0d", write_count, group));
			write_count++;
		end
	end

	// one-cycle read latency
	// write lands at the same edge
	always @(posedge clock) begin
		#1;
		mem_rdata = mem[seen_addr];
		if (seen_wr) begin
			mem[seen_addr] = seen_wdata;
		end
	end

	initial begin
		logic [15:0] kind;
		logic [15:0] addr;
		logic [15:0] count;
		logic [15:0] value;
		int i;
		clock = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		mem_rdata = '0;
		seen_addr = '0;
		seen_wdata = '0;
		seen_wr = 1'b0;
		data_pos = 0;
		exp_count = 0;
		write_count = 0;
		group = 0;
		fill_memory();
		$readmemh("testbench/bus_cpu_tests.txt", test_data);
		read_field(kind);
		while (kind != 16'h0) begin
			// image goes in while reset is held
			@(posedge clock);
			#1;
			reset = 1'b1;
			fill_memory();
			exp_count = 0;
			write_count = 0;
			while (kind != 16'h3) begin
				read_field(addr);
				if (kind == 16'h1) begin
					read_field(count);
					for (i = 0; i < count; i++) begin
						read_field(value);
						mem[addr[7:0] + i[7:0]] = value;
					end
				end else if (kind == 16'h2 && exp_count < max_writes) begin
					read_field(value);
					exp_addr[exp_count] = addr[7:0];
					exp_word[exp_count] = value;
					exp_count++;
				end else begin
					$display("Bad record kind %h or too many writes in group %0d", kind, group);
					stop_run();
				end
				read_field(kind);
			end
			repeat (10) @(posedge clock);
			#1;
			reset = 1'b0;
			// single-cycle start strobe
			@(posedge clock);
			#1;
			start = 1'b1;
			@(posedge clock);
			#1;
			start = 1'b0;
			wait_for_end();
			check_count(write_count, exp_count, $sformatf("writes in group %0d", group));
			group++;
			read_field(kind);
		end
		if (group == group_total) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("Data file holds %0d test groups instead of %0d", group, group_total);
			stop_run();
		end
	end

endmodule

`default_nettype wire

/* rtl/bus_cpu.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_cpu (
	input wire logic clock,
	input wire logic reset,
	input wire logic start,
	input wire bus_cpu_pkg::word_t mem_rdata,
	output bus_cpu_pkg::addr_t mem_addr,
	output bus_cpu_pkg::word_t mem_wdata,
	output logic mem_wr,
	output logic end_process
);

	// control word and status between the two halves
	datapath_ctrl_if ctrl_if_i ();

	// micro-state machine
	control_sequencer control_sequencer_i (
		.clock(clock),
		.reset(reset),
		.start(start),
		.ctrl(ctrl_if_i.sequencer),
		.end_process(end_process)
	);

	// registers, bus and alu
	datapath datapath_i (
		.clock(clock),
		.reset(reset),
		.ctrl(ctrl_if_i.datapath),
		.mem_rdata(mem_rdata),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_wr(mem_wr)
	);

endmodule

`default_nettype wire

/* rtl/control_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module control_sequencer (
	input wire logic clock,
	input wire logic reset,
	input wire logic start,
	datapath_ctrl_if.sequencer ctrl,
	output logic end_process
);

	bus_cpu_pkg::seq_state_t state;
	bus_cpu_pkg::seq_state_t state_next;
	bus_cpu_pkg::opcode_t opcode;

	// ir holds the opcode for the whole execution
	assign opcode = bus_cpu_pkg::opcode_t'(ctrl.opcode);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= bus_cpu_pkg::s_idle;
		end else begin
			state <= state_next;
		end
	end

	// halt is sticky, so this holds until reset
	always_ff @(posedge clock) begin
		if (reset) begin
			end_process <= 1'b0;
		end else begin
			end_process <= (state == bus_cpu_pkg::s_halt);
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			bus_cpu_pkg::s_idle: begin
				if (start) begin
					state_next = bus_cpu_pkg::s_fetch1;
				end
			end
			bus_cpu_pkg::s_fetch1: state_next = bus_cpu_pkg::s_fetch2;
			bus_cpu_pkg::s_fetch2: state_next = bus_cpu_pkg::s_fetch3;
			bus_cpu_pkg::s_fetch3: state_next = bus_cpu_pkg::s_decode;
			bus_cpu_pkg::s_decode: begin
				case (opcode)
					bus_cpu_pkg::op_loada: state_next = bus_cpu_pkg::s_loada1;
					bus_cpu_pkg::op_loadb: state_next = bus_cpu_pkg::s_loadb1;
					bus_cpu_pkg::op_store: state_next = bus_cpu_pkg::s_store1;
					bus_cpu_pkg::op_jumpz: state_next = bus_cpu_pkg::s_jumpz1;
					bus_cpu_pkg::op_jumpn: state_next = bus_cpu_pkg::s_jumpn1;
					bus_cpu_pkg::op_mv_ac_r1: state_next = bus_cpu_pkg::s_mv_ac_r1;
					bus_cpu_pkg::op_mv_ac_r2: state_next = bus_cpu_pkg::s_mv_ac_r2;
					bus_cpu_pkg::op_mv_r2_r1: state_next = bus_cpu_pkg::s_mv_r2_r1;
					bus_cpu_pkg::op_add,
					bus_cpu_pkg::op_sub,
					bus_cpu_pkg::op_mul: state_next = bus_cpu_pkg::s_alu_start;
					bus_cpu_pkg::op_clr_r2: state_next = bus_cpu_pkg::s_clr_r2;
					bus_cpu_pkg::op_end: state_next = bus_cpu_pkg::s_halt;
					bus_cpu_pkg::op_nop: state_next = bus_cpu_pkg::s_nop;
					// unknown codes run as nop
					default: state_next = bus_cpu_pkg::s_nop;
				endcase
			end
			bus_cpu_pkg::s_loada1: state_next = bus_cpu_pkg::s_loada2;
			bus_cpu_pkg::s_loada2: state_next = bus_cpu_pkg::s_loada3;
			bus_cpu_pkg::s_loadb1: state_next = bus_cpu_pkg::s_loadb2;
			bus_cpu_pkg::s_loadb2: state_next = bus_cpu_pkg::s_loadb3;
			bus_cpu_pkg::s_store1: state_next = bus_cpu_pkg::s_store2;
			bus_cpu_pkg::s_store2: state_next = bus_cpu_pkg::s_store3;
			bus_cpu_pkg::s_jumpz1: state_next = bus_cpu_pkg::s_jumpz2;
			bus_cpu_pkg::s_jumpn1: state_next = bus_cpu_pkg::s_jumpn2;
			// operand word is on mem_rdata in the take/skip cycle
			bus_cpu_pkg::s_jumpz2: begin
				state_next = ctrl.ac_zero ? bus_cpu_pkg::s_jump_take : bus_cpu_pkg::s_jump_skip;
			end
			bus_cpu_pkg::s_jumpn2: begin
				state_next = ctrl.ac_zero ? bus_cpu_pkg::s_jump_skip : bus_cpu_pkg::s_jump_take;
			end
			bus_cpu_pkg::s_alu_start: state_next = bus_cpu_pkg::s_alu_load;
			bus_cpu_pkg::s_halt: state_next = bus_cpu_pkg::s_halt;
			// last cycle of every instruction
			bus_cpu_pkg::s_loada3,
			bus_cpu_pkg::s_loadb3,
			bus_cpu_pkg::s_store3,
			bus_cpu_pkg::s_jump_take,
			bus_cpu_pkg::s_jump_skip,
			bus_cpu_pkg::s_mv_ac_r1,
			bus_cpu_pkg::s_mv_ac_r2,
			bus_cpu_pkg::s_mv_r2_r1,
			bus_cpu_pkg::s_clr_r2,
			bus_cpu_pkg::s_alu_load,
			bus_cpu_pkg::s_nop: state_next = bus_cpu_pkg::s_fetch1;
			default: state_next = bus_cpu_pkg::s_idle;
		endcase
	end

	// control word, everything inactive unless the state asks
	always_comb begin
		ctrl.bus_src = bus_cpu_pkg::src_none;
		ctrl.load_ar = 1'b0;
		ctrl.load_pc = 1'b0;
		ctrl.load_ir = 1'b0;
		ctrl.load_ac = 1'b0;
		ctrl.load_ac_alu = 1'b0;
		ctrl.load_r1 = 1'b0;
		ctrl.load_r2 = 1'b0;
		ctrl.inc_pc = 1'b0;
		ctrl.clr_r2 = 1'b0;
		ctrl.addr_from_ar = 1'b0;
		ctrl.alu_op = bus_cpu_pkg::alu_pass;
		ctrl.alu_start = 1'b0;
		ctrl.mem_wr = 1'b0;
		case (state)
			// pc already on mem_addr since fetch1
			bus_cpu_pkg::s_fetch3: begin
				ctrl.bus_src = bus_cpu_pkg::src_mem;
				ctrl.load_ir = 1'b1;
				ctrl.inc_pc = 1'b1;
			end
			// operand word, address register and step past it
			bus_cpu_pkg::s_loada1,
			bus_cpu_pkg::s_store1: begin
				ctrl.bus_src = bus_cpu_pkg::src_mem;
				ctrl.load_ar = 1'b1;
				ctrl.inc_pc = 1'b1;
			end
			bus_cpu_pkg::s_loadb1: begin
				ctrl.bus_src = bus_cpu_pkg::src_ac;
				ctrl.load_ar = 1'b1;
			end
			// read wait on the ar address
			bus_cpu_pkg::s_loada2,
			bus_cpu_pkg::s_loadb2,
			bus_cpu_pkg::s_store2: ctrl.addr_from_ar = 1'b1;
			bus_cpu_pkg::s_loada3,
			bus_cpu_pkg::s_loadb3: begin
				ctrl.addr_from_ar = 1'b1;
				ctrl.bus_src = bus_cpu_pkg::src_mem;
				ctrl.load_ac = 1'b1;
			end
			bus_cpu_pkg::s_store3: begin
				ctrl.addr_from_ar = 1'b1;
				ctrl.mem_wr = 1'b1;
			end
			bus_cpu_pkg::s_jump_take: begin
				ctrl.bus_src = bus_cpu_pkg::src_mem;
				ctrl.load_pc = 1'b1;
			end
			bus_cpu_pkg::s_jump_skip: ctrl.inc_pc = 1'b1;
			bus_cpu_pkg::s_mv_ac_r1: begin
				ctrl.bus_src = bus_cpu_pkg::src_ac;
				ctrl.load_r1 = 1'b1;
			end
			bus_cpu_pkg::s_mv_ac_r2: begin
				ctrl.bus_src = bus_cpu_pkg::src_ac;
				ctrl.load_r2 = 1'b1;
			end
			bus_cpu_pkg::s_mv_r2_r1: begin
				ctrl.bus_src = bus_cpu_pkg::src_r2;
				ctrl.load_r1 = 1'b1;
			end
			bus_cpu_pkg::s_clr_r2: ctrl.clr_r2 = 1'b1;
			// function comes from the opcode still in ir
			bus_cpu_pkg::s_alu_start: begin
				ctrl.alu_start = 1'b1;
				case (opcode)
					bus_cpu_pkg::op_add: ctrl.alu_op = bus_cpu_pkg::alu_add;
					bus_cpu_pkg::op_sub: ctrl.alu_op = bus_cpu_pkg::alu_sub;
					bus_cpu_pkg::op_mul: ctrl.alu_op = bus_cpu_pkg::alu_mul;
					default: ctrl.alu_op = bus_cpu_pkg::alu_pass;
				endcase
			end
			bus_cpu_pkg::s_alu_load: ctrl.load_ac_alu = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/datapath.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bus_cpu_settings.svh"

module datapath (
	input wire logic clock,
	input wire logic reset,
	datapath_ctrl_if.datapath ctrl,
	input wire bus_cpu_pkg::word_t mem_rdata,
	output bus_cpu_pkg::addr_t mem_addr,
	output bus_cpu_pkg::word_t mem_wdata,
	output logic mem_wr
);

	bus_cpu_pkg::addr_t pc;
	bus_cpu_pkg::addr_t ar;
	bus_cpu_pkg::word_t ir;
	bus_cpu_pkg::word_t ac;
	bus_cpu_pkg::word_t r1;
	bus_cpu_pkg::word_t r2;
	bus_cpu_pkg::word_t bus;
	bus_cpu_pkg::word_t alu_result;

	// internal bus mux
	always_comb begin
		case (bus_cpu_pkg::bus_src_t'(ctrl.bus_src))
			bus_cpu_pkg::src_mem: bus = mem_rdata;
			bus_cpu_pkg::src_ac: bus = ac;
			bus_cpu_pkg::src_r2: bus = r2;
			default: bus = '0;
		endcase
	end

	// pc load takes the low address bits of the bus
	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;
		end else if (ctrl.load_pc) begin
			pc <= bus[`BUS_CPU_ADDR_WIDTH-1:0];
		end else if (ctrl.inc_pc) begin
			pc <= pc + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ar <= '0;
			ir <= '0;
		end else begin
			if (ctrl.load_ar) begin
				ar <= bus[`BUS_CPU_ADDR_WIDTH-1:0];
			end
			if (ctrl.load_ir) begin
				ir <= bus;
			end
		end
	end

	// accumulator from bus or from the alu
	always_ff @(posedge clock) begin
		if (reset) begin
			ac <= '0;
		end else if (ctrl.load_ac_alu) begin
			ac <= alu_result;
		end else if (ctrl.load_ac) begin
			ac <= bus;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			r1 <= '0;
			r2 <= '0;
		end else begin
			if (ctrl.load_r1) begin
				r1 <= bus;
			end
			if (ctrl.clr_r2) begin
				r2 <= '0;
			end else if (ctrl.load_r2) begin
				r2 <= bus;
			end
		end
	end

	alu_unit alu_unit_i (
		.clock(clock),
		.reset(reset),
		.start(ctrl.alu_start),
		.op(bus_cpu_pkg::alu_op_t'(ctrl.alu_op)),
		.a(r1),
		.b(r2),
		.result(alu_result)
	);

	// status for the sequencer
	assign ctrl.opcode = ir[`BUS_CPU_OPCODE_WIDTH-1:0];
	assign ctrl.ac_zero = (ac == '0);

	// memory side
	assign mem_addr = ctrl.addr_from_ar ? ar : pc;
	assign mem_wdata = ac;
	assign mem_wr = ctrl.mem_wr;

endmodule

`default_nettype wire

/* rtl/alu_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_unit (
	input wire logic clock,
	input wire logic reset,
	input wire logic start,
	input wire bus_cpu_pkg::alu_op_t op,
	input wire bus_cpu_pkg::word_t a,
	input wire bus_cpu_pkg::word_t b,
	output bus_cpu_pkg::word_t result
);

	// one result, held until the next start
	always_ff @(posedge clock) begin
		if (reset) begin
			result <= '0;
		end else if (start) begin
			case (op)
				bus_cpu_pkg::alu_add: result <= a + b;
				bus_cpu_pkg::alu_sub: result <= a - b;
				// truncated to the word, low half of the product
				bus_cpu_pkg::alu_mul: result <= a * b;
				default: result <= a;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/datapath_ctrl_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bus_cpu_settings.svh"

interface datapath_ctrl_if;

	// bus driver, bus_src_t encoding
	logic [2:0] bus_src;
	// register loads from the bus
	logic load_ar;
	logic load_pc;
	logic load_ir;
	logic load_ac;
	logic load_r1;
	logic load_r2;
	// accumulator from alu result
	logic load_ac_alu;
	logic inc_pc;
	logic clr_r2;
	// memory address from ar instead of pc
	logic addr_from_ar;
	// alu_op_t encoding
	logic [1:0] alu_op;
	logic alu_start;
	logic mem_wr;

	// status back to the sequencer
	logic [`BUS_CPU_OPCODE_WIDTH-1:0] opcode;
	logic ac_zero;

	modport sequencer (
		output bus_src, load_ar, load_pc, load_ir, load_ac, load_ac_alu, load_r1, load_r2,
		output inc_pc, clr_r2, addr_from_ar, alu_op, alu_start, mem_wr,
		input opcode, ac_zero
	);

	modport datapath (
		input bus_src, load_ar, load_pc, load_ir, load_ac, load_ac_alu, load_r1, load_r2,
		input inc_pc, clr_r2, addr_from_ar, alu_op, alu_start, mem_wr,
		output opcode, ac_zero
	);

endinterface

`default_nettype wire

/* rtl/bus_cpu_pkg.sv */
`default_nettype none

`include "bus_cpu_settings.svh"

package bus_cpu_pkg;

	// data word and memory address
	typedef logic [`BUS_CPU_WORD_WIDTH-1:0] word_t;
	typedef logic [`BUS_CPU_ADDR_WIDTH-1:0] addr_t;

	// opcodes, instruction bits 5..0
	// codes follow the old control unit state numbers
	typedef enum logic [`BUS_CPU_OPCODE_WIDTH-1:0] {
		op_loada    = 6'd3,
		op_loadb    = 6'd5,
		op_store    = 6'd7,
		op_jumpz    = 6'd9,
		op_jumpn    = 6'd13,
		op_mv_r2_r1 = 6'd20,
		op_mv_ac_r1 = 6'd38,
		op_mv_ac_r2 = 6'd39,
		op_mul      = 6'd41,
		op_add      = 6'd42,
		op_sub      = 6'd43,
		op_clr_r2   = 6'd46,
		op_nop      = 6'd47,
		op_end      = 6'd48
	} opcode_t;

	// sequencer micro-states
	typedef enum logic [5:0] {
		s_idle,
		s_fetch1,
		s_fetch2,
		s_fetch3,
		s_decode,
		s_loada1,
		s_loada2,
		s_loada3,
		s_loadb1,
		s_loadb2,
		s_loadb3,
		s_store1,
		s_store2,
		s_store3,
		s_jumpz1,
		s_jumpz2,
		s_jumpn1,
		s_jumpn2,
		s_jump_take,
		s_jump_skip,
		s_mv_ac_r1,
		s_mv_ac_r2,
		s_mv_r2_r1,
		s_clr_r2,
		s_alu_start,
		s_alu_load,
		s_nop,
		s_halt
	} seq_state_t;

	// internal bus driver
	typedef enum logic [2:0] {
		src_none,
		src_mem,
		src_ac,
		src_r1,
		src_r2
	} bus_src_t;

	// alu function
	typedef enum logic [1:0] {
		alu_pass,
		alu_add,
		alu_sub,
		alu_mul
	} alu_op_t;

endpackage

`default_nettype wire

/* rtl/bus_cpu_settings.svh */
`ifndef BUS_CPU_SETTINGS_SVH
`define BUS_CPU_SETTINGS_SVH

// data and instruction word
`define BUS_CPU_WORD_WIDTH 16

// memory address, 256 words
`define BUS_CPU_ADDR_WIDTH 8

// opcode field, low bits of the instruction
`define BUS_CPU_OPCODE_WIDTH 6

`endif
